/* design/derm_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Buffer geometry and shared types for the de-rate-matching input stage.
// One position is one 48-bit bank word; 16 positions make one buffer row.
////////////////////////////////////////////////////////////////////////////
`default_nettype none

package derm_pkg;

  localparam int NUM_BANKS = 16;
  localparam int BANK_W    = 48;
  localparam int RX_W      = 96;          // Demux LLR word
  localparam int POS_W     = 14;
  localparam int SEL_W     = 4;           // log2 of NUM_BANKS
  localparam int ROW_W     = POS_W - SEL_W;
  localparam int BUF_AW    = ROW_W + 1;   // Ping-pong bit on top of the row
  localparam int USER_W    = 3;

  // Low SEL_W bits pick the bank, the rest pick the row
  typedef logic [POS_W-1:0] pos_t;

  typedef struct packed {
    logic [POS_W-1:0] e0_sz;      // Positions minus one
    logic [POS_W-1:0] e1_sz;
    logic [7:0]       e0_num;
    logic [3:0]       qm;
    logic             two_layer;
  } user_cfg_t;

  typedef struct packed {
    logic              valid;
    logic [USER_W-1:0] user;
    logic [BUF_AW-1:0] row;
    logic [SEL_W-1:0]  bank_sel;
    logic              two_layer;
  } wr_cmd_t;

  typedef struct packed {
    logic              valid;
    logic [USER_W-1:0] user;
    pos_t              size;      // Counter value at completion
  } cb_done_t;

  // One full buffer row, bank 0 in the low bits
  typedef logic [NUM_BANKS-1:0][BANK_W-1:0] bank_data_t;

endpackage

`default_nettype wire

/* design/derm_user_layout.sv */
////////////////////////////////////////////////////////////////////////////
// Start positions are valid 8 cycles after slot start, when o_start_load
// pulses. Configuration must stay stable until then.
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module derm_user_layout
  import derm_pkg::*;
#(
  parameter int N_USERS = 8
)
(
  input  logic      i_core_clk,
  input  logic      i_rx_rstn,
  input  logic      i_rdm_slot_start,
  input  user_cfg_t i_user_cfg [N_USERS],
  output pos_t      o_user_start [N_USERS],
  output logic      o_start_load
);

  localparam logic [3:0] LOAD_STEP  = 4'd8;
  localparam int         AREA_LIMIT = 1 << POS_W;   // 1024 rows
  localparam int         SUM_W      = POS_W + USER_W + 1;

  logic [3:0]        step_cnt;
  logic [USER_W-1:0] step_idx;
  logic [SUM_W-1:0]  area_sum;    // Holds all users at full size
  logic [ROW_W:0]    area_rows;
  logic [POS_W:0]    user_area;

  assign step_idx = step_cnt[USER_W-1:0];

  // E1 area rounded up to whole rows
  assign area_rows = {1'b0, i_user_cfg[step_idx].e1_sz[POS_W-1:SEL_W]} + (ROW_W + 1)'(1);
  assign user_area = {area_rows, {SEL_W{1'b0}}};

  always_ff @(posedge i_core_clk or negedge i_rx_rstn)
  begin
    if (!i_rx_rstn)
    begin
      step_cnt <= '0;
      area_sum <= '0;
      for (int u = 0; u < N_USERS; u++)
        o_user_start[u] <= '0;
    end
    else
    begin
      if (i_rdm_slot_start)
        step_cnt <= '0;
      else if (step_cnt <= LOAD_STEP)
        step_cnt <= step_cnt + 4'd1;   // Parks at 9

      if (int'(step_cnt) < N_USERS)
      begin
        if (step_cnt == '0)
        begin
          o_user_start[step_idx] <= '0;
          area_sum               <= SUM_W'(user_area);
        end
        else
        begin
          o_user_start[step_idx] <= area_sum[POS_W-1:0];
          area_sum               <= area_sum + SUM_W'(user_area);
        end
      end
    end
  end

  assign o_start_load = (step_cnt == LOAD_STEP);

  // All user areas together must fit in one ping-pong half
  a_layout_fits: assert property (@(posedge i_core_clk) disable iff (!i_rx_rstn)
    o_start_load |-> (int'(area_sum) <= AREA_LIMIT));

endmodule

`default_nettype wire

/* design/derm_user_tracker.sv */
////////////////////////////////////////////////////////////////////////////
// Strobes must arrive at least 10 cycles after slot start. Ping-pong flags
// survive slot start; only reset clears them.
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module derm_user_tracker
  import derm_pkg::*;
#(
  parameter int N_USERS = 8
)
(
  input  logic               i_core_clk,
  input  logic               i_rx_rstn,
  input  logic               i_rdm_slot_start,
  input  logic               i_start_load,
  input  pos_t               i_user_start [N_USERS],
  input  user_cfg_t          i_user_cfg [N_USERS],
  input  logic               i_demux_strb,
  input  logic [USER_W-1:0]  i_demux_user_idx,
  input  logic [USER_W-1:0]  i_rd_user,
  input  logic [ROW_W-1:0]   i_rd_offset,
  output wr_cmd_t            o_wr_cmd,
  output logic [BUF_AW-1:0]  o_rd_row,
  output logic [N_USERS-1:0] o_pingpong,
  output cb_done_t           o_cb_done
);

  pos_t               cb_pos   [N_USERS];   // Position inside current CB
  pos_t               wr_pos   [N_USERS];   // Absolute buffer position
  logic [7:0]         cb_cnt   [N_USERS];
  pos_t               cb_limit [N_USERS];
  logic [1:0]         step     [N_USERS];
  logic [N_USERS-1:0] pingpong;
  logic [N_USERS-1:0] upd;
  logic [N_USERS-1:0] wrap;
  pos_t               sel_wr_pos;
  pos_t               sel_cb_pos;
  logic               sel_flag;
  logic               sel_two_layer;
  pos_t               rd_start;
  logic               rd_flag;

  always_comb
  begin
    for (int u = 0; u < N_USERS; u++)
    begin
      cb_limit[u] = (cb_cnt[u] < i_user_cfg[u].e0_num) ? i_user_cfg[u].e0_sz
                                                      : i_user_cfg[u].e1_sz;
      wrap[u]     = (cb_pos[u] >= cb_limit[u]);
      step[u]     = i_user_cfg[u].two_layer ? 2'd2 : 2'd1;
      upd[u]      = i_demux_strb && !i_rdm_slot_start &&
                    (i_demux_user_idx == USER_W'(u));
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Per-user counters
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge i_core_clk or negedge i_rx_rstn)
  begin
    if (!i_rx_rstn)
    begin
      for (int u = 0; u < N_USERS; u++)
      begin
        cb_pos[u] <= '0;
        wr_pos[u] <= '0;
        cb_cnt[u] <= '0;
      end
      pingpong <= '0;
    end
    else
    begin
      for (int u = 0; u < N_USERS; u++)
      begin
        if (i_rdm_slot_start)
        begin
          cb_pos[u] <= '0;
          cb_cnt[u] <= '0;
        end
        else if (upd[u] && !wrap[u])
          cb_pos[u] <= cb_pos[u] + pos_t'(step[u]);
        else if (upd[u])
        begin
          cb_pos[u]   <= '0;
          cb_cnt[u]   <= cb_cnt[u] + 8'd1;
          pingpong[u] <= ~pingpong[u];   // Finished CB, switch half
        end

        if (i_start_load)
          wr_pos[u] <= i_user_start[u];
        else if (upd[u])
          wr_pos[u] <= wrap[u] ? i_user_start[u] : wr_pos[u] + pos_t'(step[u]);
      end
    end
  end

  always_ff @(posedge i_core_clk or negedge i_rx_rstn)
  begin
    if (!i_rx_rstn)
      o_cb_done <= '0;
    else
    begin
      o_cb_done.valid <= |(upd & wrap);
      o_cb_done.user  <= i_demux_user_idx;
      o_cb_done.size  <= sel_cb_pos;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Write and read address select
  ////////////////////////////////////////////////////////////////////////////
  always_comb
  begin
    sel_wr_pos    = '0;
    sel_cb_pos    = '0;
    sel_flag      = 1'b0;
    sel_two_layer = 1'b0;
    rd_start      = '0;
    rd_flag       = 1'b0;
    for (int u = 0; u < N_USERS; u++)
    begin
      if (i_demux_user_idx == USER_W'(u))
      begin
        sel_wr_pos    = wr_pos[u];
        sel_cb_pos    = cb_pos[u];
        sel_flag      = pingpong[u];
        sel_two_layer = i_user_cfg[u].two_layer;
      end
      if (i_rd_user == USER_W'(u))
      begin
        rd_start = i_user_start[u];
        rd_flag  = pingpong[u];
      end
    end
  end

  always_comb
  begin
    o_wr_cmd.valid     = i_demux_strb;
    o_wr_cmd.user      = i_demux_user_idx;
    o_wr_cmd.row       = {sel_flag, sel_wr_pos[POS_W-1:SEL_W]};
    o_wr_cmd.bank_sel  = sel_wr_pos[SEL_W-1:0];
    o_wr_cmd.two_layer = sel_two_layer;
  end

  // Reads go to the half that is not being written
  assign o_rd_row   = {~rd_flag, rd_start[POS_W-1:SEL_W] + i_rd_offset};
  assign o_pingpong = pingpong;

  a_user_in_range: assert property (@(posedge i_core_clk) disable iff (!i_rx_rstn)
    i_demux_strb |-> (int'(i_demux_user_idx) < N_USERS));

endmodule

`default_nettype wire

/* design/derm_write_format.sv */
////////////////////////////////////////////////////////////////////////////
// Two-layer packing supports qm of 1, 2, 4, 6 and 8; other values write
// zeros. Purely combinational.
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module derm_write_format
  import derm_pkg::*;
#(
  parameter int N_USERS = 8
)
(
  input  wr_cmd_t              i_wr_cmd,
  input  logic [RX_W-1:0]      i_demux_rx,
  input  user_cfg_t            i_user_cfg [N_USERS],
  output logic [NUM_BANKS-1:0] o_bank_we,
  output logic [BUF_AW-1:0]    o_wr_row,
  output bank_data_t           o_wr_data
);

  logic [3:0]        qm;
  logic [BANK_W-1:0] even_word;
  logic [BANK_W-1:0] odd_word;

  always_comb
  begin
    qm = '0;
    for (int u = 0; u < N_USERS; u++)
      if (i_wr_cmd.user == USER_W'(u))
        qm = i_user_cfg[u].qm;
  end

  // Second layer starts right after 6*qm bits of the first
  always_comb
  begin
    even_word = '0;
    odd_word  = '0;
    case (qm)
      4'd1:
      begin
        even_word = BANK_W'(i_demux_rx[5:0]);
        odd_word  = BANK_W'(i_demux_rx[11:6]);
      end
      4'd2:
      begin
        even_word = BANK_W'(i_demux_rx[11:0]);
        odd_word  = BANK_W'(i_demux_rx[23:12]);
      end
      4'd4:
      begin
        even_word = BANK_W'(i_demux_rx[23:0]);
        odd_word  = BANK_W'(i_demux_rx[47:24]);
      end
      4'd6:
      begin
        even_word = BANK_W'(i_demux_rx[35:0]);
        odd_word  = BANK_W'(i_demux_rx[71:36]);
      end
      4'd8:
      begin
        even_word = i_demux_rx[BANK_W-1:0];
        odd_word  = i_demux_rx[RX_W-1:BANK_W];
      end
      default: even_word = '0;
    endcase

    for (int b = 0; b < NUM_BANKS; b++)
      o_wr_data[b] = !i_wr_cmd.two_layer ? i_demux_rx[BANK_W-1:0] :
                     (b % 2 != 0)        ? odd_word : even_word;
  end

  always_comb
  begin
    if (!i_wr_cmd.valid)
      o_bank_we = '0;
    else if (i_wr_cmd.two_layer)
      o_bank_we = NUM_BANKS'(2'b11) << {i_wr_cmd.bank_sel[SEL_W-1:1], 1'b0};
    else
      o_bank_we = NUM_BANKS'(1) << i_wr_cmd.bank_sel;

    // A two-layer write starts on the even bank of its pair
    if (i_wr_cmd.valid && i_wr_cmd.two_layer)
      a_pair_aligned: assert (!i_wr_cmd.bank_sel[0]);
  end

  assign o_wr_row = i_wr_cmd.row;

endmodule

`default_nettype wire

/* design/derm_input_buffer.sv */
////////////////////////////////////////////////////////////////////////////
// Simple dual-port RAM, one read cycle latency. A read of the row being
// written returns the old word.
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module derm_input_buffer
  import derm_pkg::*;
(
  input  logic                 i_core_clk,
  input  logic [NUM_BANKS-1:0] i_bank_we,
  input  logic [BUF_AW-1:0]    i_wr_row,
  input  bank_data_t           i_wr_data,
  input  logic [BUF_AW-1:0]    i_rd_row,
  output bank_data_t           o_rd_data
);

  localparam int DEPTH = 1 << BUF_AW;   // Both ping-pong halves

  for (genvar b = 0; b < NUM_BANKS; b++)
  begin : g_bank
    logic [BANK_W-1:0] mem [DEPTH];
    logic [BANK_W-1:0] rd_q;

    always_ff @(posedge i_core_clk)
    begin
      if (i_bank_we[b])
        mem[i_wr_row] <= i_wr_data[b];
      rd_q <= mem[i_rd_row];
    end

    assign o_rd_data[b] = rd_q;
  end

endmodule

`default_nettype wire

/* design/derm_input_top.sv */
////////////////////////////////////////////////////////////////////////////
// Input stage of NR uplink de-rate-matching, no back-pressure. Leave 10
// cycles between i_rdm_slot_start and the first demux strobe.
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module derm_input_top
  import derm_pkg::*;
#(
  parameter int N_USERS = 8
)
(
  input  logic               i_core_clk,
  input  logic               i_rx_rstn,
  input  logic               i_rdm_slot_start,
  input  user_cfg_t          i_user_cfg [N_USERS],
  input  logic               i_demux_strb,
  input  logic [USER_W-1:0]  i_demux_user_idx,
  input  logic [RX_W-1:0]    i_demux_rx,
  input  logic [USER_W-1:0]  i_rd_user,
  input  logic [ROW_W-1:0]   i_rd_offset,
  output bank_data_t         o_rd_data,
  output logic [N_USERS-1:0] o_pingpong,
  output cb_done_t           o_cb_done
);

  pos_t                 user_start [N_USERS];
  logic                 start_load;
  wr_cmd_t              wr_cmd;
  logic [BUF_AW-1:0]    rd_row;
  logic [NUM_BANKS-1:0] bank_we;
  logic [BUF_AW-1:0]    wr_row;
  bank_data_t           wr_data;

  derm_user_layout #(.N_USERS(N_USERS)) u_layout (
    .i_core_clk       (i_core_clk),
    .i_rx_rstn        (i_rx_rstn),
    .i_rdm_slot_start (i_rdm_slot_start),
    .i_user_cfg       (i_user_cfg),
    .o_user_start     (user_start),
    .o_start_load     (start_load)
  );

  derm_user_tracker #(.N_USERS(N_USERS)) u_tracker (
    .i_core_clk       (i_core_clk),
    .i_rx_rstn        (i_rx_rstn),
    .i_rdm_slot_start (i_rdm_slot_start),
    .i_start_load     (start_load),
    .i_user_start     (user_start),
    .i_user_cfg       (i_user_cfg),
    .i_demux_strb     (i_demux_strb),
    .i_demux_user_idx (i_demux_user_idx),
    .i_rd_user        (i_rd_user),
    .i_rd_offset      (i_rd_offset),
    .o_wr_cmd         (wr_cmd),
    .o_rd_row         (rd_row),
    .o_pingpong       (o_pingpong),
    .o_cb_done        (o_cb_done)
  );

  derm_write_format #(.N_USERS(N_USERS)) u_format (
    .i_wr_cmd   (wr_cmd),
    .i_demux_rx (i_demux_rx),
    .i_user_cfg (i_user_cfg),
    .o_bank_we  (bank_we),
    .o_wr_row   (wr_row),
    .o_wr_data  (wr_data)
  );

  derm_input_buffer u_buffer (
    .i_core_clk (i_core_clk),
    .i_bank_we  (bank_we),
    .i_wr_row   (wr_row),
    .i_wr_data  (wr_data),
    .i_rd_row   (rd_row),
    .o_rd_data  (o_rd_data)
  );

endmodule

`default_nettype wire

/* verif/tb_derm_input.sv */
////////////////////////////////////////////////////////////////////////////
// Random demux traffic from a fixed LCG seed, checked against a shadow copy
// of the buffer. E1 sizes stay small so all eight user areas fit one half.
////////////////////////////////////////////////////////////////////////////
`default_nettype none

module tb_derm_input
  import derm_pkg::*;
();

  localparam int N_USERS      = 8;
  localparam int CMP_W        = NUM_BANKS * BANK_W;
  localparam int DRAIN_LIMIT  = 100;
  localparam int STROBE_LIMIT = 20000;

  typedef logic [CMP_W-1:0] cmp_t;

  logic               clk;
  logic               rstn;
  logic               slot_start;
  user_cfg_t          user_cfg [N_USERS];
  logic               strb;
  logic [USER_W-1:0]  strb_user;
  logic [RX_W-1:0]    rx;
  logic [USER_W-1:0]  rd_user;
  logic [ROW_W-1:0]   rd_offset;
  bank_data_t         rd_data;
  logic [N_USERS-1:0] pingpong;
  cb_done_t           cb_done;

  // Reference model state
  user_cfg_t            cfg      [N_USERS];
  pos_t                 m_start  [N_USERS];
  pos_t                 m_cb_pos [N_USERS];
  pos_t                 m_wr_pos [N_USERS];
  int                   m_cb_cnt [N_USERS];
  int                   m_left   [N_USERS];   // CBs still to finish in this run
  logic [N_USERS-1:0]   m_flag;
  logic [BANK_W-1:0]    shadow   [1 << BUF_AW][NUM_BANKS];
  logic [NUM_BANKS-1:0] written  [1 << BUF_AW];
  logic [17:0]          done_q   [$];         // {new flag, user, size}
  logic [31:0]          seed;
  int                   errors;
  int                   checks;
  int                   tests;
  int                   failed_tests;
  int                   test_errors;
  string                test_name;

  derm_input_top #(.N_USERS(N_USERS)) i_dut (
    .i_core_clk       (clk),
    .i_rx_rstn        (rstn),
    .i_rdm_slot_start (slot_start),
    .i_user_cfg       (user_cfg),
    .i_demux_strb     (strb),
    .i_demux_user_idx (strb_user),
    .i_demux_rx       (rx),
    .i_rd_user        (rd_user),
    .i_rd_offset      (rd_offset),
    .o_rd_data        (rd_data),
    .o_pingpong       (pingpong),
    .o_cb_done        (cb_done)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic logic [3:0] qm_pick(input int i);
    case (i)
      0: return 4'd1;
      1: return 4'd2;
      2: return 4'd4;
      3: return 4'd6;
      4: return 4'd8;
      default: return 4'd3;   // Unsupported qm packs zeros
    endcase
  endfunction

  task automatic check_value(input string what, input cmp_t exp_val, input cmp_t act_val);
    checks++;
    if (act_val !== exp_val)
    begin
      errors++;
      $display("[ERROR] %s %s expected %0h actual %0h", test_name, what, exp_val, act_val);
    end
  endtask

  task automatic begin_test(input string name);
    test_name   = name;
    test_errors = errors;
  endtask

  task automatic end_test();
    tests++;
    if (errors != test_errors)
      failed_tests++;
    $display("test %s finished with %0d errors", test_name, errors - test_errors);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Model of one strobe, ahead of the clock edge that takes it
  ////////////////////////////////////////////////////////////////////////////
  task automatic model_strobe(input int u, input logic [RX_W-1:0] data);
    logic [BUF_AW-1:0] row;
    logic [RX_W-1:0]   mask;
    pos_t              limit;
    int                bank;
    int                w;
    int                step;
    row  = {m_flag[u], m_wr_pos[u][POS_W-1:SEL_W]};
    bank = int'(m_wr_pos[u][SEL_W-1:0]);
    step = cfg[u].two_layer ? 2 : 1;
    if (!cfg[u].two_layer)
    begin
      shadow[row][bank]  = data[BANK_W-1:0];
      written[row][bank] = 1'b1;
    end
    else
    begin
      w    = (cfg[u].qm inside {4'd1, 4'd2, 4'd4, 4'd6, 4'd8}) ? 6 * int'(cfg[u].qm) : 0;
      mask = (RX_W'(1) << w) - RX_W'(1);
      bank = bank & ~1;
      shadow[row][bank]      = BANK_W'(data & mask);
      shadow[row][bank + 1]  = BANK_W'((data >> w) & mask);
      written[row][bank]     = 1'b1;
      written[row][bank + 1] = 1'b1;
    end
    limit = (m_cb_cnt[u] < int'(cfg[u].e0_num)) ? cfg[u].e0_sz : cfg[u].e1_sz;
    if (m_cb_pos[u] < limit)
    begin
      m_cb_pos[u] = m_cb_pos[u] + pos_t'(step);
      m_wr_pos[u] = m_wr_pos[u] + pos_t'(step);
    end
    else
    begin
      done_q.push_back({~m_flag[u], USER_W'(u), m_cb_pos[u]});
      m_flag[u]   = ~m_flag[u];
      m_cb_pos[u] = '0;
      m_wr_pos[u] = m_start[u];
      m_cb_cnt[u]++;
      m_left[u]--;
    end
  endtask

  task automatic make_cfg(input bit two_layer, input int e0_num);
    pos_t e1;
    for (int u = 0; u < N_USERS; u++)
    begin
      e1                = pos_t'(32'd8 + lcg_next() % 32'd64);
      cfg[u].e1_sz      = e1;
      cfg[u].e0_sz      = pos_t'(32'd2 + lcg_next() % (32'(e1) - 32'd1));
      cfg[u].e0_num     = (e0_num < 0) ? 8'(lcg_next() % 32'd3) : 8'(e0_num);
      cfg[u].two_layer  = two_layer && (u < 6);
      cfg[u].qm         = cfg[u].two_layer ? qm_pick(u) : qm_pick(int'(lcg_next() % 32'd5));
      if (cfg[u].two_layer)
      begin
        cfg[u].e1_sz[0] = 1'b0;   // Even limits keep the last pair inside the area
        cfg[u].e0_sz[0] = 1'b0;
      end
    end
  endtask

  task automatic start_slot();
    @(posedge clk);
    for (int u = 0; u < N_USERS; u++)
      user_cfg[u] <= cfg[u];
    slot_start <= 1'b1;
    @(posedge clk);
    slot_start <= 1'b0;
    m_start[0] = '0;
    for (int u = 1; u < N_USERS; u++)
      m_start[u] = m_start[u-1] + {cfg[u-1].e1_sz[POS_W-1:SEL_W], {SEL_W{1'b0}}} + pos_t'(16);
    for (int u = 0; u < N_USERS; u++)
    begin
      m_cb_pos[u] = '0;
      m_wr_pos[u] = m_start[u];
      m_cb_cnt[u] = 0;
    end
    repeat (10) @(posedge clk);   // Layout needs 8 cycles
  endtask

  task automatic drive_strobe(input int u);
    logic [RX_W-1:0] data;
    data = {lcg_next(), lcg_next(), lcg_next()};
    @(posedge clk);
    strb      <= 1'b1;
    strb_user <= USER_W'(u);
    rx        <= data;
    model_strobe(u, data);
  endtask

  task automatic idle_cycle();
    @(posedge clk);
    strb <= 1'b0;
  endtask

  // Every user finishes n_cb CBs in random user order
  task automatic run_cbs(input int n_cb);
    int u;
    int pending;
    int guard;
    int left_before;
    int t;
    for (int i = 0; i < N_USERS; i++)
      m_left[i] = n_cb;
    pending = N_USERS * n_cb;
    guard   = 0;
    while (pending > 0 && guard < STROBE_LIMIT)
    begin
      u = int'((lcg_next() >> 16) % 32'(N_USERS));
      while (m_left[u] == 0)
        u = (u + 1) % N_USERS;
      left_before = m_left[u];
      drive_strobe(u);
      if (m_left[u] != left_before)
        pending--;
      if ((lcg_next() & 32'hf) == 32'h0)
        idle_cycle();
      guard++;
    end
    idle_cycle();
    if (pending > 0)
    begin
      errors++;
      $display("%s: strobe limit reached with %0d CBs unfinished", test_name, pending);
    end
    t = 0;
    while (done_q.size() != 0 && t < DRAIN_LIMIT)
    begin
      @(negedge clk);
      t++;
    end
    if (done_q.size() != 0)
    begin
      errors++;
      $display("%s: timed out waiting for %0d CB completions", test_name, done_q.size());
    end
    @(negedge clk);
    check_value("pingpong", cmp_t'(m_flag), cmp_t'(pingpong));
  endtask

  // Reads every row of each user's completed half with one cycle of latency
  task automatic read_back();
    logic [BUF_AW-1:0] row;
    bank_data_t        exp_row;
    cmp_t              mask;
    int                rows;
    for (int u = 0; u < N_USERS; u++)
    begin
      rows = int'(cfg[u].e1_sz[POS_W-1:SEL_W]) + 1;
      for (int off = 0; off < rows; off++)
      begin
        row = {~m_flag[u], m_start[u][POS_W-1:SEL_W] + ROW_W'(off)};
        @(posedge clk);
        rd_user   <= USER_W'(u);
        rd_offset <= ROW_W'(off);
        @(posedge clk);
        @(negedge clk);
        for (int b = 0; b < NUM_BANKS; b++)
        begin
          exp_row[b]               = shadow[row][b];
          mask[b*BANK_W +: BANK_W] = {BANK_W{written[row][b]}};
        end
        check_value("read row", cmp_t'(exp_row) & mask, cmp_t'(rd_data) & mask);
      end
    end
  endtask

  task automatic watch_done();
    logic [17:0] entry;
    forever
    begin
      @(negedge clk);
      if (rstn && cb_done.valid)
      begin
        if (done_q.size() == 0)
        begin
          errors++;
          $display("%s: CB completion from user %0d was not expected", test_name, cb_done.user);
        end
        else
        begin
          entry = done_q.pop_front();
          check_value("cb_done", cmp_t'(entry[16:0]), cmp_t'({cb_done.user, cb_done.size}));
          check_value("pingpong bit", cmp_t'(entry[17]), cmp_t'(pingpong[cb_done.user]));
        end
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////
  initial
  begin
    logic [N_USERS-1:0] saved_flag;
    seed         = 32'h0891015b;
    errors       = 0;
    checks       = 0;
    tests        = 0;
    failed_tests = 0;
    m_flag       = '0;
    test_name    = "setup";
    for (int r = 0; r < (1 << BUF_AW); r++)
      written[r] = '0;
    rstn       <= 1'b0;
    slot_start <= 1'b0;
    strb       <= 1'b0;
    strb_user  <= '0;
    rx         <= '0;
    rd_user    <= '0;
    rd_offset  <= '0;
    for (int u = 0; u < N_USERS; u++)
      user_cfg[u] <= '0;
    repeat (4) @(posedge clk);
    rstn <= 1'b1;
    fork
      watch_done();
    join_none

    begin_test("reset_state");
    @(negedge clk);
    check_value("pingpong", '0, cmp_t'(pingpong));
    for (int i = 0; i < 20; i++)
    begin
      @(negedge clk);
      check_value("cb_done valid", '0, cmp_t'(cb_done.valid));
    end
    end_test();

    begin_test("one_layer");
    make_cfg(1'b0, -1);
    start_slot();
    run_cbs(3);
    read_back();
    end_test();

    begin_test("two_layer_packing");
    make_cfg(1'b1, -1);
    start_slot();
    run_cbs(2);
    read_back();
    end_test();

    begin_test("e0_e1_limits");
    make_cfg(1'b0, 2);
    start_slot();
    run_cbs(4);
    read_back();
    end_test();

    begin_test("new_slot");
    saved_flag = m_flag;
    for (int u = 0; u < N_USERS; u++)
      cfg[u].e1_sz = cfg[u].e1_sz + pos_t'(16);
    start_slot();
    @(negedge clk);
    check_value("pingpong after slot start", cmp_t'(saved_flag), cmp_t'(pingpong));
    run_cbs(3);
    read_back();
    end_test();

    $display("tests %0d, failed %0d, checks %0d, errors %0d", tests, failed_tests, checks, errors);
    if (errors == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
design/derm_pkg.sv
design/derm_user_layout.sv
design/derm_user_tracker.sv
design/derm_write_format.sv
design/derm_input_buffer.sv
design/derm_input_top.sv
verif/tb_derm_input.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_derm_input
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
JOBS      ?= 4

SOURCES := $(shell cat $(FLIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FLIST)
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q '^>>> PASS$$'

clean:
	rm -rf $(OBJ_DIR)
